/* source/console_pkg.sv */
package console_pkg;

    // packet type codes shared by the host side and the device side.
    typedef enum logic [3:0] {
        INIT   = 4'd0,
        ACK    = 4'd1,
        NAK    = 4'd2,
        STL    = 4'd3,
        DIDX   = 4'd5,
        DPARAM = 4'd6,
        DDIDX  = 4'd7,
        DLINK  = 4'd8,
        DTYPE  = 4'd9,
        DTEMP  = 4'd10,
        DATA0  = 4'd13,
        DATA1  = 4'd14,
        ERROR  = 4'd15
    } btype_t;

    localparam int CMD_W  = 16;
    localparam int STAT_W = 16; // temperature in the upper byte, identity in the lower.
    localparam int TYPE_W = 2;

    localparam logic [7:0] ID_ALPHA = 8'h55;
    localparam logic [7:0] ID_BETA  = 8'hAA;
    localparam logic [7:0] ID_GAMMA = 8'hFF;

    // an inactive slot reads as an unknown device.
    function automatic logic [TYPE_W-1:0] id_to_type(input logic active, input logic [7:0] id);
        if (!active) begin
            return '0;
        end
        case (id)
            ID_ALPHA: return 2'd1;
            ID_BETA:  return 2'd2;
            ID_GAMMA: return 2'd3;
            default:  return 2'd0;
        endcase
    endfunction

    // command word, then one type code and one temperature byte per slot.
    function automatic int info_width(input int num_dev);
        return CMD_W + num_dev * (TYPE_W + 8);
    endfunction

endpackage

/* source/console_link_if.sv */
`timescale 1ns/100ps

// one decoded operation, handed from decode to the sweep.
interface console_op_if;
    import console_pkg::*;

    logic             valid;
    logic             ready;
    logic             conv;
    btype_t           send_btype;
    btype_t           read_btype;
    logic [CMD_W-1:0] cmd;

    modport source (output valid, conv, send_btype, read_btype, cmd, input ready);
    modport sink   (input valid, conv, send_btype, read_btype, cmd, output ready);
endinterface

// a finished sweep, handed on to the collector.
interface console_done_if;
    import console_pkg::*;

    logic             valid;
    logic             ready;
    logic             conv;
    logic [CMD_W-1:0] cmd;

    modport source (output valid, conv, cmd, input ready);
    modport sink   (input valid, conv, cmd, output ready);
endinterface

/* source/console_cmd_decode.sv */
`timescale 1ns/100ps

module console_cmd_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_conv,
    input  logic [console_pkg::CMD_W-1:0]  req_cmd,
    console_op_if.source                   op
);
    import console_pkg::*;

    btype_t read_hist;
    logic   req_fire;

    // configure reads temperatures, converts alternate between the two data packets.
    function automatic btype_t next_read(input logic conv, input btype_t cur);
        if (!conv) begin
            return DTEMP;
        end
        case (cur)
            DATA0:   return DATA1;
            default: return DATA0; // INIT, DTEMP and DATA1 all restart on DATA0.
        endcase
    endfunction

    assign req_ready = !op.valid;
    assign req_fire  = req_valid && req_ready;

    // the history register doubles as the read type of the held operation.
    assign op.read_btype = read_hist;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op.valid  <= 1'b0;
            read_hist <= INIT;
        end else begin
            if (req_fire) begin
                op.valid  <= 1'b1;
                read_hist <= next_read(req_conv, read_hist);
            end else if (op.ready) begin
                op.valid <= 1'b0; // the sweep took it.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            op.conv <= req_conv;
            op.cmd  <= req_cmd;
            if (req_conv) begin
                op.send_btype <= DIDX;
            end else begin
                op.send_btype <= DPARAM;
            end
        end
    end

endmodule

/* source/console_device_sweep.sv */
`timescale 1ns/100ps

module console_device_sweep #(
    parameter int NUM_DEV = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    console_op_if.sink                    op,
    console_done_if.source                done,
    input  logic [NUM_DEV-1:0]            dev_active,
    input  logic [NUM_DEV-1:0]            send_done,
    input  logic [NUM_DEV-1:0]            read_busy,
    output logic                          send_start,
    output logic                          read_start,
    output console_pkg::btype_t           send_btype,
    output console_pkg::btype_t           read_btype,
    output logic [console_pkg::CMD_W-1:0] conf_cmd
);
    import console_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND,
        S_READ_RISE,
        S_READ_FALL,
        S_DONE
    } sweep_state_t;

    sweep_state_t state;
    logic         op_fire;
    logic         sent_all;
    logic         busy_all;
    logic         busy_none;

    // inactive slots are forced to look finished.
    assign sent_all  = &(send_done | ~dev_active);
    assign busy_all  = &(read_busy | ~dev_active);
    assign busy_none = ~|(read_busy & dev_active);

    assign op.ready   = (state == S_IDLE);
    assign op_fire    = op.valid && op.ready;
    assign send_start = (state == S_SEND);
    assign read_start = (state == S_READ_RISE) || (state == S_READ_FALL);
    assign done.valid = (state == S_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (op_fire) state <= S_SEND;
                end
                S_SEND: begin
                    if (sent_all) state <= S_READ_RISE;
                end
                S_READ_RISE: begin
                    if (busy_all) state <= S_READ_FALL;
                end
                S_READ_FALL: begin
                    if (busy_none) state <= S_DONE;
                end
                S_DONE: begin
                    if (done.ready) state <= S_IDLE; // held here while the collector is full.
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_btype <= INIT;
            read_btype <= INIT;
            conf_cmd   <= '0;
        end else if (op_fire) begin
            send_btype <= op.send_btype;
            read_btype <= op.read_btype;
            if (!op.conv) begin
                conf_cmd <= op.cmd; // converts keep the last configure command.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            done.conv <= op.conv;
            done.cmd  <= op.cmd;
        end
    end

endmodule

/* source/console_status_collect.sv */
`timescale 1ns/100ps

module console_status_collect #(
    parameter int NUM_DEV = 8
) (
    input  logic                                         clk,
    input  logic                                         rst,
    console_done_if.sink                                 done,
    input  logic [NUM_DEV*console_pkg::STAT_W-1:0]       dev_status,
    input  logic [NUM_DEV-1:0]                           dev_active,
    output logic                                         rsp_valid,
    input  logic                                         rsp_ready,
    output logic                                         rsp_conv,
    output logic [console_pkg::info_width(NUM_DEV)-1:0]  rsp_info
);
    import console_pkg::*;

    logic [NUM_DEV*TYPE_W-1:0] type_bits;
    logic [NUM_DEV*8-1:0]      temp_bits;
    logic                      done_fire;

    // slot i sits at dev_status[i*STAT_W +: STAT_W].
    // in the packed fields slot 0 lands in the most significant position.
    always_comb begin
        for (int i = 0; i < NUM_DEV; i++) begin
            type_bits[(NUM_DEV-1-i)*TYPE_W +: TYPE_W] =
                id_to_type(dev_active[i], dev_status[i*STAT_W +: 8]);
            if (dev_active[i]) begin
                temp_bits[(NUM_DEV-1-i)*8 +: 8] = dev_status[i*STAT_W+STAT_W-8 +: 8];
            end else begin
                temp_bits[(NUM_DEV-1-i)*8 +: 8] = 8'h00;
            end
        end
    end

    assign done.ready = !rsp_valid; // only one response is held at a time.
    assign done_fire  = done.valid && done.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_conv  <= 1'b0;
            rsp_info  <= '0;
        end else begin
            if (done_fire) begin
                rsp_valid <= 1'b1;
                rsp_conv  <= done.conv;
                if (!done.conv) begin
                    rsp_info <= {done.cmd, type_bits, temp_bits};
                end
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

endmodule

/* source/console_hq.sv */
`timescale 1ns/100ps

module console_hq #(
    parameter int NUM_DEV = 8
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         req_valid,
    output logic                                         req_ready,
    input  logic                                         req_conv,
    input  logic [console_pkg::CMD_W-1:0]                req_cmd,
    output logic                                         rsp_valid,
    input  logic                                         rsp_ready,
    output logic                                         rsp_conv,
    output logic [console_pkg::info_width(NUM_DEV)-1:0]  rsp_info,
    input  logic [NUM_DEV-1:0]                           dev_active,
    input  logic [NUM_DEV-1:0]                           send_done,
    input  logic [NUM_DEV-1:0]                           read_busy,
    input  logic [NUM_DEV*console_pkg::STAT_W-1:0]       dev_status,
    output logic                                         send_start,
    output logic                                         read_start,
    output console_pkg::btype_t                          send_btype,
    output console_pkg::btype_t                          read_btype,
    output logic [console_pkg::CMD_W-1:0]                conf_cmd
);

    console_op_if   op_link ();
    console_done_if done_link ();

    console_cmd_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_conv  (req_conv),
        .req_cmd   (req_cmd),
        .op        (op_link.source)
    );

    console_device_sweep #(.NUM_DEV(NUM_DEV)) u_sweep (
        .clk        (clk),
        .rst        (rst),
        .op         (op_link.sink),
        .done       (done_link.source),
        .dev_active (dev_active),
        .send_done  (send_done),
        .read_busy  (read_busy),
        .send_start (send_start),
        .read_start (read_start),
        .send_btype (send_btype),
        .read_btype (read_btype),
        .conf_cmd   (conf_cmd)
    );

    // status is sampled as the sweep hands over, so it reflects the finished read phase.
    console_status_collect #(.NUM_DEV(NUM_DEV)) u_collect (
        .clk        (clk),
        .rst        (rst),
        .done       (done_link.sink),
        .dev_status (dev_status),
        .dev_active (dev_active),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_conv   (rsp_conv),
        .rsp_info   (rsp_info)
    );

endmodule

/* test/console_hq_tb.sv */
`timescale 1ns/100ps

module console_hq_tb;
    import console_pkg::*;

    localparam int NUM_DEV = 8;
    localparam int INFO_W  = info_width(NUM_DEV);
    localparam int NUM_REQ = 40;
    localparam int LIMIT   = NUM_REQ * 80;

    logic clk, rst, req_valid, req_ready, req_conv, rsp_valid, rsp_ready, rsp_conv;
    logic [15:0] req_cmd, conf_cmd;
    logic [INFO_W-1:0] rsp_info;
    logic [NUM_DEV-1:0] dev_active, send_done, read_busy;
    logic [NUM_DEV*16-1:0] dev_status;
    logic send_start, read_start;
    btype_t send_btype, read_btype;

    integer seed = 70;
    int errors = 0, cycles = 0, rst_cycles = 0, sent = 0, rsp_count = 0;
    int send_cnt[NUM_DEV], rd_wait[NUM_DEV], rd_hold[NUM_DEV], rd_phase[NUM_DEV];
    logic fire_pending = 0, prev_send = 0, prev_read = 0, prev_sent_ok = 0, prev_busy_any = 0;
    logic all_busy_seen = 0, was_held = 0, held_conv;
    logic [INFO_W-1:0] held_info, model_info = '0, info;
    btype_t hist = INIT;
    logic [15:0] model_conf = '0;
    logic q_conv[$], r_conv[$];
    logic [15:0] q_cmd[$], q_conf[$];
    btype_t q_send[$], q_read[$];
    logic [INFO_W-1:0] r_info[$];
    int r;

    console_hq #(.NUM_DEV(NUM_DEV)) uut (.*);

    function automatic int pick(input int n);
        int v;
        v = $random(seed);
        return (v & 32'h7fffffff) % n;
    endfunction

    function automatic logic [1:0] type_code(input logic [7:0] id);
        if (id == 8'h55) return 2'd1;
        if (id == 8'hAA) return 2'd2;
        if (id == 8'hFF) return 2'd3;
        return 2'd0;
    endfunction

    task automatic report_mismatch(input string name, input logic [INFO_W-1:0] exp,
                                   input logic [INFO_W-1:0] act);
        errors++;
        $display("error: %s expected %h actual %h", name, exp, act);
    endtask

    // a new sweep has started, so check its types and load fresh device status.
    task automatic start_sweep();
        logic [7:0] id;
        if (q_conv.size() == 0) begin
            errors++;
            $display("send_start rose with no request outstanding");
            return;
        end
        if (send_btype != q_send[0]) report_mismatch("send_btype", q_send[0], send_btype);
        if (read_btype != q_read[0]) report_mismatch("read_btype", q_read[0], read_btype);
        if (conf_cmd != q_conf[0]) report_mismatch("conf_cmd", q_conf[0], conf_cmd);
        r = $random(seed);
        dev_active = (pick(5) == 0) ? '0 : r[NUM_DEV-1:0];
        for (int i = 0; i < NUM_DEV; i++) begin
            r = $random(seed);
            case (pick(4))
                0: id = 8'h55;
                1: id = 8'hAA;
                2: id = 8'hFF;
                default: id = r[7:0];
            endcase
            dev_status[i*16 +: 16] = {r[15:8], id};
        end
        if (!q_conv[0]) begin
            info = '0;
            info[INFO_W-1 -: 16] = q_cmd[0];
            for (int i = 0; i < NUM_DEV; i++) begin
                if (dev_active[i]) begin
                    info[NUM_DEV*8 + (NUM_DEV-1-i)*2 +: 2] = type_code(dev_status[i*16 +: 8]);
                    info[(NUM_DEV-1-i)*8 +: 8] = dev_status[i*16+8 +: 8];
                end
            end
            model_info = info;
        end
        r_conv.push_back(q_conv[0]);
        r_info.push_back(model_info);
        void'(q_conv.pop_front());
        void'(q_cmd.pop_front());
        void'(q_send.pop_front());
        void'(q_read.pop_front());
        void'(q_conf.pop_front());
    endtask

    // each slot answers after a random delay; inactive slots toggle freely.
    task automatic drive_devices();
        logic busy_full;
        busy_full = &(read_busy | ~dev_active);
        all_busy_seen = read_start && (all_busy_seen || busy_full);
        for (int i = 0; i < NUM_DEV; i++) begin
            if (!send_start) begin
                send_done[i] = 1'b0;
                send_cnt[i] = pick(5);
            end else if (send_cnt[i] == 0) begin
                send_done[i] = 1'b1;
            end else begin
                send_cnt[i]--;
            end
            if (!read_start) begin
                read_busy[i] = 1'b0;
                rd_phase[i] = 0;
                rd_wait[i] = pick(5);
                rd_hold[i] = 1 + pick(3);
            end else if (rd_phase[i] == 0) begin
                if (rd_wait[i] == 0) begin
                    read_busy[i] = 1'b1;
                    rd_phase[i] = 1;
                end else begin
                    rd_wait[i]--;
                end
            end else if (rd_phase[i] == 1 && all_busy_seen) begin
                if (rd_hold[i] <= 1) begin
                    read_busy[i] = 1'b0;
                    rd_phase[i] = 2;
                end else begin
                    rd_hold[i]--;
                end
            end
            if (!dev_active[i]) begin
                r = $random(seed);
                send_done[i] = r[0];
                read_busy[i] = r[1];
            end
        end
    endtask

    task automatic drive_host();
        if (fire_pending) begin
            req_valid = 1'b0;
            fire_pending = 1'b0;
        end
        if (!req_valid && sent < NUM_REQ && pick(4) == 0) begin
            r = $random(seed);
            req_valid = 1'b1;
            req_conv = r[16];
            req_cmd = r[15:0];
            sent++;
        end
        if (req_valid && req_ready) begin
            hist = !req_conv ? DTEMP : (hist == DATA0) ? DATA1 : DATA0;
            if (!req_conv) model_conf = req_cmd;
            q_conv.push_back(req_conv);
            q_cmd.push_back(req_cmd);
            q_send.push_back(req_conv ? DIDX : DPARAM);
            q_read.push_back(hist);
            q_conf.push_back(model_conf);
            fire_pending = 1'b1;
        end
        rsp_ready = (pick(4) != 0);
    endtask

    task automatic check_response();
        if (rsp_valid) begin
            if (was_held && (rsp_info != held_info || rsp_conv != held_conv)) begin
                errors++;
                $display("response changed while held under back-pressure");
            end
            if (rsp_ready) begin
                if (r_conv.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding");
                end else begin
                    if (rsp_conv != r_conv[0]) report_mismatch("rsp_conv", r_conv[0], rsp_conv);
                    if (rsp_info != r_info[0]) report_mismatch("rsp_info", r_info[0], rsp_info);
                    void'(r_conv.pop_front());
                    void'(r_info.pop_front());
                end
                rsp_count++;
            end
        end
        was_held = rsp_valid && !rsp_ready;
        held_info = rsp_info;
        held_conv = rsp_conv;
    endtask

    initial begin
        clk = 0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_cycles < 3) begin
            if (send_start || read_start || rsp_valid ||
                send_btype != INIT || read_btype != INIT) begin
                errors++;
                $display("outputs not idle during reset");
            end
            rst_cycles++;
            if (rst_cycles == 3) rst = 1'b0;
        end else begin
            cycles++;
            if (cycles == 1 && (!req_ready || send_start || read_start || rsp_valid ||
                                send_btype != INIT || read_btype != INIT)) begin
                errors++;
                $display("controller not idle after reset");
            end
            if (prev_send && !send_start && !prev_sent_ok) begin
                errors++;
                $display("send_start fell before every active slot sent");
            end
            if (prev_read && !read_start && prev_busy_any) begin
                errors++;
                $display("read_start fell while an active slot was busy");
            end
            if (send_start && !prev_send) start_sweep();
            drive_devices();
            drive_host();
            check_response();
            prev_send = send_start;
            prev_read = read_start;
            prev_sent_ok = &(send_done | ~dev_active);
            prev_busy_any = |(read_busy & dev_active);
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_conv = 1'b0;
        req_cmd = '0;
        rsp_ready = 1'b0;
        dev_active = '0;
        send_done = '0;
        read_busy = '0;
        dev_status = '0;
        while (rsp_count < NUM_REQ && cycles < LIMIT) @(posedge clk);
        if (rsp_count < NUM_REQ) begin
            errors++;
            $display("timeout: run stopped after %0d cycles with %0d of %0d responses",
                     cycles, rsp_count, NUM_REQ);
        end
        $display("%0d requests, %0d responses, %0d errors", sent, rsp_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/console_pkg.sv
source/console_link_if.sv
source/console_cmd_decode.sv
source/console_device_sweep.sv
source/console_status_collect.sv
source/console_hq.sv
test/console_hq_tb.sv

/* Makefile */
all: run

build:
	verilator --binary --timing -f verilog.f --top-module console_hq_tb -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall -f verilog.f --top-module console_hq

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
